// ==== verilog.f ====
buf_cfg_pkg.sv
buf_data_pkg.sv
line_mem_if.sv
line_ram.sv
dma_loader.sv
bank_router.sv
read_sequencer.sv
weight_buffer_top.sv
tb_clock_gen.sv
weight_buffer_properties.sv
tb_weight_buffer.sv

// ==== Bender.yml ====
package:
  name: weight_buffer

sources:
  - buf_cfg_pkg.sv
  - buf_data_pkg.sv
  - line_mem_if.sv
  - line_ram.sv
  - dma_loader.sv
  - bank_router.sv
  - read_sequencer.sv
  - weight_buffer_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - weight_buffer_properties.sv
      - tb_weight_buffer.sv

// ==== tb_weight_buffer.sv ====
`timescale 1ns/1ps

module tb_weight_buffer;

    localparam int PERIOD_NS = 40;
    localparam int LAT       = buf_cfg_pkg::READ_LATENCY;
    localparam int WPL       = buf_cfg_pkg::WORDS_PER_LINE;
    localparam int WDEPTH    = buf_cfg_pkg::WEIGHT_DEPTH;
    localparam int BDEPTH    = buf_cfg_pkg::BIAS_DEPTH;

    // cycle budget of each test
    localparam int BUDGET_RESET = 20;
    localparam int BUDGET_LOAD  = WDEPTH * WPL + 60;
    localparam int BUDGET_WRAP  = 40;
    localparam int BUDGET_BIAS  = 140;
    localparam int BUDGET_SWAP  = WDEPTH * WPL + 80;
    localparam int BUDGET_IFM   = 4 * WPL + 40;
    localparam int BUDGET_TOTAL = BUDGET_RESET + BUDGET_LOAD + BUDGET_WRAP
                                + BUDGET_BIAS + BUDGET_SWAP + BUDGET_IFM;

    logic                            clk;
    logic                            rstn;
    logic [buf_cfg_pkg::LAYER_W-1:0] layer_i;
    buf_data_pkg::dma_word_t         dma_data_i;
    logic [1:0]                      dma_sel_i;
    logic                            dma_v_i;
    logic                            ready_w_i;
    logic                            ready_b_i;
    logic [buf_cfg_pkg::LINE_W-1:0]  weight_o;
    buf_data_pkg::bias_t             bias_o;
    logic                            valid_w_o;
    logic                            valid_b_o;

    // ========================================
    // reference model and expected reads
    // ========================================

    buf_data_pkg::weight_line_u bank_model [2][WDEPTH];
    buf_data_pkg::bias_t        bias_model [BDEPTH];
    buf_data_pkg::weight_line_u partial_line;
    int word_idx;
    int line_ptr;
    int bias_ptr;
    int rd_w_ptr;
    int rd_b_ptr;
    int fill_sel;

    buf_data_pkg::weight_line_u exp_w_q [$];
    buf_data_pkg::bias_t        exp_b_q [$];
    int due_w_q [$];
    int due_b_q [$];
    int addr_w_q [$];
    int addr_b_q [$];

    int cyc;
    int errors;
    int checks;
    int tests_failed;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(2)) u_clk (
        .clk  (clk),
        .rstn (rstn)
    );

    weight_buffer_top uut (
        .clk        (clk),
        .rstn       (rstn),
        .layer_i    (layer_i),
        .dma_data_i (dma_data_i),
        .dma_sel_i  (dma_sel_i),
        .dma_v_i    (dma_v_i),
        .ready_w_i  (ready_w_i),
        .ready_b_i  (ready_b_i),
        .weight_o   (weight_o),
        .bias_o     (bias_o),
        .valid_w_o  (valid_w_o),
        .valid_b_o  (valid_b_o)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic compare_weight(input buf_data_pkg::weight_line_u got,
                                  input buf_data_pkg::weight_line_u exp,
                                  input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0d ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_bias(input buf_data_pkg::bias_t got,
                                input buf_data_pkg::bias_t exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0d ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // apply a taken DMA word to the model
    function automatic void store_dma(input logic [1:0] sel, input buf_data_pkg::dma_word_t data);
        if (sel == buf_cfg_pkg::DMA_WEIGHT) begin
            partial_line.words[word_idx] = data;
            word_idx++;
            if (word_idx == WPL) begin
                bank_model[fill_sel][line_ptr] = partial_line;
                line_ptr = (line_ptr + 1) % WDEPTH;
                word_idx = 0;
            end
        end else if (sel == buf_cfg_pkg::DMA_BIAS) begin
            bias_model[bias_ptr] = data;
            bias_ptr = (bias_ptr + 1) % BDEPTH;
        end
    endfunction

    // one clock of stimulus, set on the falling edge
    task automatic drive_cycle(input logic v, input logic [1:0] sel,
                               input buf_data_pkg::dma_word_t data,
                               input logic rw, input logic rb);
        @(negedge clk);
        dma_v_i    = v;
        dma_sel_i  = sel;
        dma_data_i = data;
        ready_w_i  = rw;
        ready_b_i  = rb;
        if (v) begin
            store_dma(sel, data);
        end
        if (rw) begin
            exp_w_q.push_back(bank_model[1 - fill_sel][rd_w_ptr]);
            addr_w_q.push_back(rd_w_ptr);
            due_w_q.push_back(cyc + LAT);
            rd_w_ptr = (rd_w_ptr + 1) % WDEPTH;
        end
        if (rb) begin
            exp_b_q.push_back(bias_model[rd_b_ptr]);
            addr_b_q.push_back(rd_b_ptr);
            due_b_q.push_back(cyc + LAT);
            rd_b_ptr = (rd_b_ptr + 1) % BDEPTH;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, 2'd0, '0, 1'b0, 1'b0);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((due_w_q.size() != 0 || due_b_q.size() != 0) && n < 4 * LAT) begin
            idle_cycles(1);
            n++;
        end
        if (due_w_q.size() != 0 || due_b_q.size() != 0) begin
            errors++;
            $display("read data did not come back within %0d cycles", 4 * LAT);
            exp_w_q.delete();
            exp_b_q.delete();
            due_w_q.delete();
            due_b_q.delete();
            addr_w_q.delete();
            addr_b_q.delete();
        end
    endtask

    // quiet window around the layer change
    task automatic change_layer(input int next_layer);
        wait_drain();
        idle_cycles(2);
        @(negedge clk);
        layer_i  = next_layer[buf_cfg_pkg::LAYER_W-1:0];
        fill_sel = 1 - fill_sel;
        word_idx = 0;
        line_ptr = 0;
        bias_ptr = 0;
        rd_w_ptr = 0;
        rd_b_ptr = 0;
        idle_cycles(4);
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err0);
        end
    endtask

    // ========================================
    // output monitor
    // ========================================

    always @(negedge clk) begin : collect
        buf_data_pkg::weight_line_u exp_line;
        buf_data_pkg::bias_t        exp_word;
        int                         exp_addr;
        if (rstn) begin
            if (valid_w_o) begin
                if (due_w_q.size() == 0 || due_w_q[0] != cyc) begin
                    errors++;
                    $display("weight valid at %0d ns with no read due in this cycle", $time);
                end else begin
                    void'(due_w_q.pop_front());
                    exp_line = exp_w_q.pop_front();
                    exp_addr = addr_w_q.pop_front();
                    compare_weight(weight_o, exp_line, $sformatf("weight line %0d", exp_addr));
                end
            end else if (due_w_q.size() != 0 && due_w_q[0] == cyc) begin
                errors++;
                $display("weight valid missing at %0d ns", $time);
                void'(due_w_q.pop_front());
                void'(exp_w_q.pop_front());
                void'(addr_w_q.pop_front());
            end
            if (valid_b_o) begin
                if (due_b_q.size() == 0 || due_b_q[0] != cyc) begin
                    errors++;
                    $display("bias valid at %0d ns with no read due in this cycle", $time);
                end else begin
                    void'(due_b_q.pop_front());
                    exp_word = exp_b_q.pop_front();
                    exp_addr = addr_b_q.pop_front();
                    compare_bias(bias_o, exp_word, $sformatf("bias word %0d", exp_addr));
                end
            end else if (due_b_q.size() != 0 && due_b_q[0] == cyc) begin
                errors++;
                $display("bias valid missing at %0d ns", $time);
                void'(due_b_q.pop_front());
                void'(exp_b_q.pop_front());
                void'(addr_b_q.pop_front());
            end
        end
    end

    // ========================================
    // directed tests
    // ========================================

    task automatic reset_idle_check();
        int err0;
        err0 = errors;
        idle_cycles(10);
        report_test("valids low after reset", err0);
    endtask

    task automatic weight_readout();
        int err0;
        err0 = errors;
        for (int i = 0; i < WDEPTH * WPL; i++) begin
            drive_cycle(1'b1, buf_cfg_pkg::DMA_WEIGHT, $urandom(), 1'b0, 1'b0);
        end
        change_layer(1);
        repeat (WDEPTH) drive_cycle(1'b0, 2'd0, '0, 1'b1, 1'b0);
        wait_drain();
        report_test("weight lines read in order", err0);
    endtask

    task automatic address_wrap();
        int err0;
        err0 = errors;
        repeat (WDEPTH + 4) drive_cycle(1'b0, 2'd0, '0, 1'b1, 1'b0);
        wait_drain();
        report_test("weight address wraps", err0);
    endtask

    task automatic bias_gapped_read();
        int   err0;
        int   issued;
        logic rb;
        err0   = errors;
        issued = 0;
        repeat (20) drive_cycle(1'b1, buf_cfg_pkg::DMA_BIAS, $urandom(), 1'b0, 1'b0);
        while (issued < 20) begin
            rb = (($urandom() % 3) != 0);
            drive_cycle(1'b0, 2'd0, '0, 1'b0, rb);
            if (rb) begin
                issued++;
            end
        end
        wait_drain();
        report_test("bias reads with gaps", err0);
    endtask

    // loads go to the fill bank while the other bank is read
    task automatic pingpong_swap();
        int err0;
        err0 = errors;
        for (int i = 0; i < WDEPTH * WPL; i++) begin
            drive_cycle(1'b1, buf_cfg_pkg::DMA_WEIGHT, $urandom(), 1'b1, 1'b0);
        end
        change_layer(2);
        repeat (WDEPTH) drive_cycle(1'b0, 2'd0, '0, 1'b1, 1'b0);
        wait_drain();
        report_test("ping-pong bank swap", err0);
    endtask

    task automatic ifm_filtering();
        int err0;
        err0 = errors;
        drive_cycle(1'b1, buf_cfg_pkg::DMA_IFM, $urandom(), 1'b0, 1'b0);
        for (int i = 0; i < 2 * WPL; i++) begin
            drive_cycle(1'b1, buf_cfg_pkg::DMA_WEIGHT, $urandom(), 1'b0, 1'b0);
            if (($urandom() % 2) != 0) begin
                drive_cycle(1'b1, buf_cfg_pkg::DMA_IFM, $urandom(), 1'b0, 1'b0);
            end
        end
        change_layer(3);
        repeat (2) drive_cycle(1'b0, 2'd0, '0, 1'b1, 1'b0);
        wait_drain();
        report_test("ifm words ignored", err0);
    endtask

    // ========================================
    // run control
    // ========================================

    initial begin
        #(2 * BUDGET_TOTAL * PERIOD_NS);
        $display("watchdog expired after %0d cycles, tests did not finish", 2 * BUDGET_TOTAL);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        void'($urandom(2217));
        layer_i      = '0;
        dma_data_i   = '0;
        dma_sel_i    = 2'd0;
        dma_v_i      = 1'b0;
        ready_w_i    = 1'b0;
        ready_b_i    = 1'b0;
        word_idx     = 0;
        line_ptr     = 0;
        bias_ptr     = 0;
        rd_w_ptr     = 0;
        rd_b_ptr     = 0;
        fill_sel     = 0;
        cyc          = 0;
        errors       = 0;
        checks       = 0;
        tests_failed = 0;
        @(posedge rstn);
        reset_idle_check();
        weight_readout();
        address_wrap();
        bias_gapped_read();
        pingpong_swap();
        ifm_filtering();
        if (uut.u_props.fail_count != 0) begin
            $display("%0d assertion failures reported by the bound checker",
                     uut.u_props.fail_count);
            errors += uut.u_props.fail_count;
        end
        $display("tests run: 6, tests failed: %0d, checks: %0d, errors: %0d",
                 tests_failed, checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== weight_buffer_properties.sv ====
`timescale 1ns/1ps

module weight_buffer_properties (
    input logic       clk,
    input logic       rstn,
    input logic [1:0] dma_sel_i,
    input logic       dma_v_i,
    input logic       ready_w_i,
    input logic       ready_b_i,
    input logic       valid_w_o,
    input logic       valid_b_o
);

    localparam int LAT = buf_cfg_pkg::READ_LATENCY;

    // number of failed assertions
    int fail_count = 0;

    // ========================================
    // read handshake
    // ========================================

    // every valid answers a ready seen LAT edges before
    weight_valid_after_ready: assert property (@(posedge clk) disable iff (!rstn)
        valid_w_o |-> $past(ready_w_i, LAT))
        else begin
            fail_count++;
            $error("weight valid without a ready %0d cycles earlier", LAT);
        end

    bias_valid_after_ready: assert property (@(posedge clk) disable iff (!rstn)
        valid_b_o |-> $past(ready_b_i, LAT))
        else begin
            fail_count++;
            $error("bias valid without a ready %0d cycles earlier", LAT);
        end

    // outputs quiet while reset is held
    valids_low_in_reset: assert property (@(posedge clk)
        !rstn |-> (!valid_w_o && !valid_b_o))
        else begin
            fail_count++;
            $error("valid output high during reset");
        end

    // tag value 3 has no meaning
    dma_tag_legal: assert property (@(posedge clk) disable iff (!rstn)
        dma_v_i |-> (dma_sel_i != 2'd3))
        else begin
            fail_count++;
            $error("DMA word sent with unused tag 3");
        end

endmodule

bind weight_buffer_top weight_buffer_properties u_props (
    .clk       (clk),
    .rstn      (rstn),
    .dma_sel_i (dma_sel_i),
    .dma_v_i   (dma_v_i),
    .ready_w_i (ready_w_i),
    .ready_b_i (ready_b_i),
    .valid_w_o (valid_w_o),
    .valid_b_o (valid_b_o)
);

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // short high pulse at time zero gives the async reset a real falling edge
    initial begin
        rstn = 1'b1;
        #1;
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

// ==== weight_buffer_top.sv ====
`timescale 1ns/1ps

module weight_buffer_top (
    input  logic                            clk,
    input  logic                            rstn,

    input  logic [buf_cfg_pkg::LAYER_W-1:0] layer_i,

    input  logic [buf_cfg_pkg::DMA_W-1:0]   dma_data_i,
    input  logic [1:0]                      dma_sel_i,
    input  logic                            dma_v_i,

    input  logic                            ready_w_i,
    input  logic                            ready_b_i,

    output logic [buf_cfg_pkg::LINE_W-1:0]  weight_o,
    output logic [buf_cfg_pkg::BIAS_W-1:0]  bias_o,
    output logic                            valid_w_o,
    output logic                            valid_b_o
);

    logic                       layer_start;
    buf_data_pkg::weight_line_u w_line;

    // ========================================
    // memory ports
    // ========================================

    line_mem_if #(.WIDTH(buf_cfg_pkg::LINE_W), .DEPTH(buf_cfg_pkg::WEIGHT_DEPTH)) wfill_if ();
    line_mem_if #(.WIDTH(buf_cfg_pkg::LINE_W), .DEPTH(buf_cfg_pkg::WEIGHT_DEPTH)) wread_if ();
    line_mem_if #(.WIDTH(buf_cfg_pkg::LINE_W), .DEPTH(buf_cfg_pkg::WEIGHT_DEPTH)) bank0_if ();
    line_mem_if #(.WIDTH(buf_cfg_pkg::LINE_W), .DEPTH(buf_cfg_pkg::WEIGHT_DEPTH)) bank1_if ();
    line_mem_if #(.WIDTH(buf_cfg_pkg::BIAS_W), .DEPTH(buf_cfg_pkg::BIAS_DEPTH))   bias_if ();

    // ========================================
    // write side
    // ========================================

    dma_loader u_loader (
        .clk           (clk),
        .rstn          (rstn),
        .dma_data_i    (dma_data_i),
        .dma_sel_i     (buf_cfg_pkg::dma_sel_e'(dma_sel_i)),
        .dma_v_i       (dma_v_i),
        .layer_start_i (layer_start),
        .weight_wr     (wfill_if),
        .bias_wr       (bias_if)
    );

    bank_router u_router (
        .clk           (clk),
        .rstn          (rstn),
        .layer_i       (layer_i),
        .layer_start_o (layer_start),
        .fill          (wfill_if),
        .read          (wread_if),
        .bank0         (bank0_if),
        .bank1         (bank1_if)
    );

    // ping-pong weight banks and the bias memory
    line_ram #(.DEPTH(buf_cfg_pkg::WEIGHT_DEPTH), .WIDTH(buf_cfg_pkg::LINE_W)) u_bank0 (
        .clk (clk),
        .mem (bank0_if)
    );

    line_ram #(.DEPTH(buf_cfg_pkg::WEIGHT_DEPTH), .WIDTH(buf_cfg_pkg::LINE_W)) u_bank1 (
        .clk (clk),
        .mem (bank1_if)
    );

    line_ram #(.DEPTH(buf_cfg_pkg::BIAS_DEPTH), .WIDTH(buf_cfg_pkg::BIAS_W)) u_bias_ram (
        .clk (clk),
        .mem (bias_if)
    );

    // ========================================
    // read side
    // ========================================

    read_sequencer #(.DEPTH(buf_cfg_pkg::WEIGHT_DEPTH), .WIDTH(buf_cfg_pkg::LINE_W)) u_seq_w (
        .clk           (clk),
        .rstn          (rstn),
        .ready_i       (ready_w_i),
        .layer_start_i (layer_start),
        .mem           (wread_if),
        .data_o        (w_line),
        .valid_o       (valid_w_o)
    );

    read_sequencer #(.DEPTH(buf_cfg_pkg::BIAS_DEPTH), .WIDTH(buf_cfg_pkg::BIAS_W)) u_seq_b (
        .clk           (clk),
        .rstn          (rstn),
        .ready_i       (ready_b_i),
        .layer_start_i (layer_start),
        .mem           (bias_if),
        .data_o        (bias_o),
        .valid_o       (valid_b_o)
    );

    // taps view, tap 0 in the low bits
    assign weight_o = w_line.taps;

endmodule

// ==== read_sequencer.sv ====
`timescale 1ns/1ps

module read_sequencer #(
    parameter int DEPTH = 16,
    parameter int WIDTH = 576
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             ready_i,
    input  logic             layer_start_i,
    line_mem_if.reader       mem,
    output logic [WIDTH-1:0] data_o,
    output logic             valid_o
);

    localparam int AW  = $clog2(DEPTH);
    localparam int LAT = buf_cfg_pkg::READ_LATENCY;

    logic [AW-1:0]  cnt;
    logic [AW-1:0]  addr_q;
    logic [LAT-1:0] rdy_pipe;

    // ========================================
    // address counter and valid pipeline
    // ========================================

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt      <= '0;
            rdy_pipe <= '0;
        end else begin
            // reads in flight keep going when ready drops
            rdy_pipe <= {rdy_pipe[LAT-2:0], ready_i};
            if (layer_start_i) begin
                cnt <= '0;
            end else if (ready_i) begin
                cnt <= (cnt == AW'(DEPTH - 1)) ? '0 : cnt + 1'b1;
            end
        end
    end

    // stage one holds the issued address, stage three the output data
    always_ff @(posedge clk) begin
        if (ready_i) begin
            addr_q <= cnt;
        end
        if (rdy_pipe[LAT-2]) begin
            data_o <= mem.rd_data;
        end
    end

    assign mem.rd_en   = rdy_pipe[0];
    assign mem.rd_addr = addr_q;
    assign valid_o     = rdy_pipe[LAT-1];

endmodule

// ==== bank_router.sv ====
`timescale 1ns/1ps

module bank_router (
    input  logic                            clk,
    input  logic                            rstn,

    input  logic [buf_cfg_pkg::LAYER_W-1:0] layer_i,
    output logic                            layer_start_o,

    line_mem_if.memory                      fill,
    line_mem_if.memory                      read,

    line_mem_if.host                        bank0,
    line_mem_if.host                        bank1
);

    // ========================================
    // layer tracking
    // ========================================

    logic [buf_cfg_pkg::LAYER_W-1:0] layer_q;
    logic                            layer_chg;
    logic                            fill_bank;
    logic                            rd_bank_q;

    assign layer_chg = (layer_i != layer_q);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            layer_q       <= '0;
            layer_start_o <= 1'b0;
            fill_bank     <= 1'b0;
            rd_bank_q     <= 1'b1;
        end else begin
            layer_q       <= layer_i;
            layer_start_o <= layer_chg;
            // ping-pong swap on every new layer
            if (layer_chg) begin
                fill_bank <= ~fill_bank;
            end
            // remember which bank this read went to, data comes back next cycle
            if (read.rd_en) begin
                rd_bank_q <= ~fill_bank;
            end
        end
    end

    // ========================================
    // port steering
    // ========================================

    // writes to the fill bank
    assign bank0.wr_en   = fill.wr_en & ~fill_bank;
    assign bank0.wr_addr = fill.wr_addr;
    assign bank0.wr_data = fill.wr_data;
    assign bank1.wr_en   = fill.wr_en & fill_bank;
    assign bank1.wr_addr = fill.wr_addr;
    assign bank1.wr_data = fill.wr_data;

    // reads from the other one
    assign bank0.rd_en   = read.rd_en & fill_bank;
    assign bank0.rd_addr = read.rd_addr;
    assign bank1.rd_en   = read.rd_en & ~fill_bank;
    assign bank1.rd_addr = read.rd_addr;

    assign read.rd_data = rd_bank_q ? bank1.rd_data : bank0.rd_data;

endmodule

// ==== dma_loader.sv ====
`timescale 1ns/1ps

module dma_loader (
    input  logic                   clk,
    input  logic                   rstn,

    input  buf_data_pkg::dma_word_t dma_data_i,
    input  buf_cfg_pkg::dma_sel_e   dma_sel_i,
    input  logic                   dma_v_i,

    input  logic                   layer_start_i,

    line_mem_if.writer             weight_wr,
    line_mem_if.writer             bias_wr
);

    localparam int IDX_W = buf_cfg_pkg::WORD_IDX_W;

    // ========================================
    // tag decode
    // ========================================

    logic take_w;
    logic take_b;
    logic last_word;

    // ifm words fall through both tests and are dropped
    assign take_w = dma_v_i && (dma_sel_i == buf_cfg_pkg::DMA_WEIGHT);
    assign take_b = dma_v_i && (dma_sel_i == buf_cfg_pkg::DMA_BIAS);

    // ========================================
    // weight line assembly
    // ========================================

    logic [IDX_W-1:0]           word_cnt;
    buf_data_pkg::weight_line_u line_q;
    buf_data_pkg::weight_addr_t line_cnt;
    logic                       line_wr;

    assign last_word = (word_cnt == IDX_W'(buf_cfg_pkg::WORDS_PER_LINE - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            word_cnt <= '0;
            line_cnt <= '0;
            line_wr  <= 1'b0;
        end else if (layer_start_i) begin
            // new layer, drop any partial line
            word_cnt <= '0;
            line_cnt <= '0;
            line_wr  <= 1'b0;
        end else begin
            line_wr <= take_w && last_word;
            if (take_w) begin
                word_cnt <= last_word ? '0 : word_cnt + 1'b1;
            end
            // depth is a power of two, so the counter wraps by itself
            if (line_wr) begin
                line_cnt <= line_cnt + 1'b1;
            end
        end
    end

    // ========================================
    // bias path
    // ========================================

    buf_data_pkg::bias_addr_t bias_cnt;
    buf_data_pkg::bias_t      bias_q;
    logic                     bias_wr_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bias_cnt  <= '0;
            bias_wr_q <= 1'b0;
        end else if (layer_start_i) begin
            bias_cnt  <= '0;
            bias_wr_q <= 1'b0;
        end else begin
            bias_wr_q <= take_b;
            if (bias_wr_q) begin
                bias_cnt <= bias_cnt + 1'b1;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (take_w) begin
            line_q.words[word_cnt] <= dma_data_i;
        end
        if (take_b) begin
            bias_q <= dma_data_i;
        end
    end

    // one cycle after the last word is taken
    assign weight_wr.wr_en   = line_wr;
    assign weight_wr.wr_addr = line_cnt;
    assign weight_wr.wr_data = line_q;

    assign bias_wr.wr_en   = bias_wr_q;
    assign bias_wr.wr_addr = bias_cnt;
    assign bias_wr.wr_data = bias_q;

endmodule

// ==== line_ram.sv ====
`timescale 1ns/1ps

module line_ram #(
    parameter int DEPTH = 16,
    parameter int WIDTH = 576
) (
    input logic        clk,
    line_mem_if.memory mem
);

    // ========================================
    // storage
    // ========================================

    logic [WIDTH-1:0] ram [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            ram[mem.wr_addr] <= mem.wr_data;
        end
    end

    // read port
    // data register only loads on rd_en, holds otherwise
    always_ff @(posedge clk) begin
        if (mem.rd_en) begin
            mem.rd_data <= ram[mem.rd_addr];
        end
    end

endmodule

// ==== line_mem_if.sv ====
`timescale 1ns/1ps

interface line_mem_if #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 32
) ();

    localparam int AW = $clog2(DEPTH);

    // write port
    logic             wr_en;
    logic [AW-1:0]    wr_addr;
    logic [WIDTH-1:0] wr_data;

    // read port, data registered inside the memory
    logic             rd_en;
    logic [AW-1:0]    rd_addr;
    logic [WIDTH-1:0] rd_data;

    modport writer (output wr_en, wr_addr, wr_data);

    modport reader (output rd_en, rd_addr, input rd_data);

    // both ports from one side, used by the bank steering
    modport host (output wr_en, wr_addr, wr_data, rd_en, rd_addr, input rd_data);

    modport memory (input wr_en, wr_addr, wr_data, rd_en, rd_addr, output rd_data);

endinterface

// ==== buf_data_pkg.sv ====
package buf_data_pkg;

    // raw DMA word
    typedef logic [buf_cfg_pkg::DMA_W-1:0] dma_word_t;

    // 8 channel values of one tap
    typedef logic [buf_cfg_pkg::TAP_W-1:0] tap_t;

    typedef logic [buf_cfg_pkg::BIAS_W-1:0] bias_t;

    // ========================================
    // weight line
    // ========================================

    // filled word by word from the DMA,
    // handed to the compute array tap by tap
    typedef union packed {
        dma_word_t [buf_cfg_pkg::WORDS_PER_LINE-1:0] words;
        tap_t      [buf_cfg_pkg::TAPS-1:0]           taps;
    } weight_line_u;

    // ========================================
    // addresses
    // ========================================

    typedef logic [buf_cfg_pkg::WEIGHT_AW-1:0] weight_addr_t;
    typedef logic [buf_cfg_pkg::BIAS_AW-1:0]   bias_addr_t;

endpackage

// ==== buf_cfg_pkg.sv ====
package buf_cfg_pkg;

    // DMA side
    localparam int DMA_W = 32;

    // one kernel tap is a group of channel values
    localparam int CH_PER_TAP = 8;
    localparam int CH_W       = 8;
    localparam int TAPS       = 9;

    // derived line geometry
    localparam int TAP_W          = CH_PER_TAP * CH_W;
    localparam int LINE_W         = TAPS * TAP_W;
    localparam int WORDS_PER_LINE = LINE_W / DMA_W;
    localparam int WORD_IDX_W     = $clog2(WORDS_PER_LINE);

    // memory depths and address widths
    localparam int WEIGHT_DEPTH = 16;
    localparam int BIAS_DEPTH   = 32;
    localparam int WEIGHT_AW    = $clog2(WEIGHT_DEPTH);
    localparam int BIAS_AW      = $clog2(BIAS_DEPTH);
    localparam int BIAS_W       = 32;

    localparam int LAYER_W = 5;

    // ready to valid, in cycles
    localparam int READ_LATENCY = 3;

    // tag sent with every DMA word, value 3 is unused
    typedef enum logic [1:0] {
        DMA_WEIGHT = 2'd0,
        DMA_BIAS   = 2'd1,
        DMA_IFM    = 2'd2
    } dma_sel_e;

endpackage
